// File: core_top.f
+incdir+hdl
+incdir+tb
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/hazard_forward.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
tb/tb_core.sv

// File: hdl/core_config.svh
// core configuration macros: data width, register file size, reset address
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and address width
`define XLEN 32

// register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// address of the first fetch after reset
`define RESET_PC 32'h0000_0000

`endif

// File: hdl/core_pkg.sv
// core package: ALU op enum, control struct, pipeline register structs, forward select
`include "core_config.svh"

package core_pkg;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_SLT = 4'd4
	} alu_op_e;

	// control bits produced by decode
	typedef struct packed {
		alu_op_e alu_op;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src_imm;
		logic    branch;
		logic    branch_ne;
		logic    link;
	} ctrl_t;

	// ----------------------------------------------------------------------
	// pipeline registers
	// ----------------------------------------------------------------------

	typedef struct packed {
		ctrl_t                  ctrl;
		logic [`XLEN-1:0]       rs1_data;
		logic [`XLEN-1:0]       rs2_data;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       imm;
		logic [`XLEN-1:0]       pc_plus4;
		logic [`XLEN-1:0]       br_target;
	} id_ex_t;

	typedef struct packed {
		logic                   reg_write;
		logic                   mem_read;
		logic                   mem_write;
		logic                   link;
		logic [`XLEN-1:0]       alu_result;
		logic [`XLEN-1:0]       store_data;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       pc_plus4;
	} ex_mem_t;

	// link value already chosen in MEM, so one data field
	typedef struct packed {
		logic                   reg_write;
		logic [`XLEN-1:0]       wb_data;
		logic [`REG_ADDR_W-1:0] rd;
	} mem_wb_t;

	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

	// non-load result of the instruction in MEM
	function automatic logic [`XLEN-1:0] mem_result(input ex_mem_t em);
		return em.link ? em.pc_plus4 : em.alu_result;
	endfunction

endpackage

// File: hdl/core_top.sv
// core top level: stage instances, hazard unit and memory port wiring
`include "core_config.svh"

module core_top import core_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	output logic [`XLEN-1:0] imem_addr,
	input  logic [`XLEN-1:0] imem_data,
	output logic             dmem_ren,
	output logic             dmem_wen,
	output logic [`XLEN-1:0] dmem_addr,
	output logic [`XLEN-1:0] dmem_wdata,
	input  logic [`XLEN-1:0] dmem_rdata
);

	logic [`XLEN-1:0]       if_instr;
	logic [`XLEN-1:0]       if_pc;
	logic [`REG_ADDR_W-1:0] rs1_idx;
	logic [`REG_ADDR_W-1:0] rs2_idx;
	logic [`XLEN-1:0]       rs1_data;
	logic [`XLEN-1:0]       rs2_data;
	logic                   stall_id;
	logic                   flush_if;
	logic                   flush_id;
	logic                   jump_taken;
	logic [`XLEN-1:0]       jump_target;
	logic                   branch_taken;
	logic [`XLEN-1:0]       branch_target;
	logic [`XLEN-1:0]       mem_value;
	id_ex_t                 id_ex;
	ex_mem_t                ex_mem;
	mem_wb_t                mem_wb;
	fwd_sel_e               fwd_a;
	fwd_sel_e               fwd_b;
	fwd_sel_e               fwd_jalr;

	// data port comes straight from EX/MEM
	assign dmem_ren   = ex_mem.mem_read;
	assign dmem_wen   = ex_mem.mem_write;
	assign dmem_addr  = ex_mem.alu_result;
	assign dmem_wdata = ex_mem.store_data;

	// jalr base forwarded from MEM
	assign mem_value = mem_result(ex_mem);

	fetch_stage u_fetch (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_id      (stall_id),
		.flush_if      (flush_if),
		.jump_taken    (jump_taken),
		.branch_taken  (branch_taken),
		.jump_target   (jump_target),
		.branch_target (branch_target),
		.imem_data     (imem_data),
		.imem_addr     (imem_addr),
		.if_instr      (if_instr),
		.if_pc         (if_pc)
	);

	decode_unit u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.if_instr    (if_instr),
		.if_pc       (if_pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.stall_id    (stall_id),
		.flush_id    (flush_id),
		.fwd_jalr    (fwd_jalr),
		.mem_value   (mem_value),
		.rs1_idx     (rs1_idx),
		.rs2_idx     (rs2_idx),
		.jump_taken  (jump_taken),
		.jump_target (jump_target),
		.id_ex       (id_ex)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.wb       (mem_wb),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	hazard_forward u_hazard (
		.rs1_idx      (rs1_idx),
		.rs2_idx      (rs2_idx),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb),
		.branch_taken (branch_taken),
		.jump_taken   (jump_taken),
		.stall_id     (stall_id),
		.flush_if     (flush_if),
		.flush_id     (flush_id),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.fwd_jalr     (fwd_jalr)
	);

	execute_stage u_execute (
		.clk           (clk),
		.rst_n         (rst_n),
		.id_ex         (id_ex),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.mem_wb        (mem_wb),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.ex_mem        (ex_mem)
	);

	writeback_stage u_writeback (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_mem     (ex_mem),
		.dmem_rdata (dmem_rdata),
		.mem_wb     (mem_wb)
	);

endmodule

// File: hdl/decode_unit.sv
// decode: field split, main and ALU control, immediates, jump resolve, ID/EX register
`include "core_config.svh"

module decode_unit import core_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`XLEN-1:0]       if_instr,
	input  logic [`XLEN-1:0]       if_pc,
	input  logic [`XLEN-1:0]       rs1_data,
	input  logic [`XLEN-1:0]       rs2_data,
	input  logic                   stall_id,
	input  logic                   flush_id,
	input  fwd_sel_e               fwd_jalr,
	input  logic [`XLEN-1:0]       mem_value,
	output logic [`REG_ADDR_W-1:0] rs1_idx,
	output logic [`REG_ADDR_W-1:0] rs2_idx,
	output logic                   jump_taken,
	output logic [`XLEN-1:0]       jump_target,
	output id_ex_t                 id_ex
);

	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;

	logic [6:0]             opcode;
	logic [2:0]             funct3;
	logic                   sub_bit;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`XLEN-1:0]       imm_i;
	logic [`XLEN-1:0]       imm_s;
	logic [`XLEN-1:0]       imm_b;
	logic [`XLEN-1:0]       imm_j;
	logic [`XLEN-1:0]       imm;
	logic [`XLEN-1:0]       jalr_base;
	logic [`XLEN-1:0]       jalr_sum;
	alu_op_e                alu_fn;
	ctrl_t                  ctrl;

	assign opcode  = if_instr[6:0];
	assign rd      = if_instr[11:7];
	assign funct3  = if_instr[14:12];
	assign rs1_idx = if_instr[19:15];
	assign rs2_idx = if_instr[24:20];
	assign sub_bit = if_instr[30];

	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
		if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
		if_instr[30:21], 1'b0};

	// ALU control for R-type
	always_comb begin
		case (funct3)
			3'b000:  alu_fn = sub_bit ? ALU_SUB : ALU_ADD;
			3'b010:  alu_fn = ALU_SLT;
			3'b110:  alu_fn = ALU_OR;
			3'b111:  alu_fn = ALU_AND;
			default: alu_fn = ALU_ADD;
		endcase
	end

	// ----------------------------------------------------------------------
	// main control
	// ----------------------------------------------------------------------
	always_comb begin
		ctrl = '0;
		imm  = '0;
		case (opcode)
			OP_REG: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = alu_fn;
			end
			OP_IMM: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm              = imm_i;
			end
			OP_LOAD: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm              = imm_i;
			end
			OP_STORE: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm              = imm_s;
			end
			OP_BRANCH: begin
				// funct3[0] separates bne from beq
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = funct3[0];
				imm            = imm_b;
			end
			OP_JAL, OP_JALR: begin
				ctrl.reg_write = 1'b1;
				ctrl.link      = 1'b1;
			end
			default: ;
		endcase
	end

	// jumps resolve here, jalr base may come from MEM
	assign jump_taken = (opcode == OP_JAL) || (opcode == OP_JALR);
	assign jalr_base  = (fwd_jalr == FWD_MEM) ? mem_value : rs1_data;
	assign jalr_sum   = jalr_base + imm_i;

	always_comb begin
		if (opcode == OP_JALR)
			jump_target = {jalr_sum[`XLEN-1:1], 1'b0};
		else
			jump_target = if_pc + imm_j;
	end

	// ID/EX, bubble on stall or flush
	always_ff @(posedge clk) begin
		if (!rst_n || stall_id || flush_id)
			id_ex.ctrl <= '0;
		else
			id_ex.ctrl <= ctrl;
		id_ex.rs1_data  <= rs1_data;
		id_ex.rs2_data  <= rs2_data;
		id_ex.rs1       <= rs1_idx;
		id_ex.rs2       <= rs2_idx;
		id_ex.rd        <= rd;
		id_ex.imm       <= imm;
		id_ex.pc_plus4  <= if_pc + 4;
		id_ex.br_target <= if_pc + imm_b;
	end

endmodule

// File: hdl/execute_stage.sv
// execute stage: operand forwarding, ALU, branch decision and EX/MEM register
`include "core_config.svh"

module execute_stage import core_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  id_ex_t           id_ex,
	input  fwd_sel_e         fwd_a,
	input  fwd_sel_e         fwd_b,
	input  mem_wb_t          mem_wb,
	output logic             branch_taken,
	output logic [`XLEN-1:0] branch_target,
	output ex_mem_t          ex_mem
);

	logic [`XLEN-1:0] mem_value;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] rs2_val;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_y;
	logic             operands_eq;

	function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
		input logic [`XLEN-1:0] rf, input logic [`XLEN-1:0] mem,
		input logic [`XLEN-1:0] wb);
		case (sel)
			FWD_MEM: return mem;
			FWD_WB:  return wb;
			default: return rf;
		endcase
	endfunction

	assign mem_value = mem_result(ex_mem);
	assign op_a      = fwd_mux(fwd_a, id_ex.rs1_data, mem_value, mem_wb.wb_data);
	assign rs2_val   = fwd_mux(fwd_b, id_ex.rs2_data, mem_value, mem_wb.wb_data);
	assign op_b      = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_val;

	// ----------------------------------------------------------------------
	// ALU
	// ----------------------------------------------------------------------
	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_SUB: alu_y = op_a - op_b;
			ALU_AND: alu_y = op_a & op_b;
			ALU_OR:  alu_y = op_a | op_b;
			ALU_SLT: alu_y = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: alu_y = op_a + op_b;
		endcase
	end

	// beq / bne on register operands
	assign operands_eq   = (op_a == rs2_val);
	assign branch_taken  = id_ex.ctrl.branch && (operands_eq != id_ex.ctrl.branch_ne);
	assign branch_target = id_ex.br_target;

	// EX/MEM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.reg_write <= 1'b0;
			ex_mem.mem_read  <= 1'b0;
			ex_mem.mem_write <= 1'b0;
			ex_mem.link      <= 1'b0;
		end else begin
			ex_mem.reg_write <= id_ex.ctrl.reg_write;
			ex_mem.mem_read  <= id_ex.ctrl.mem_read;
			ex_mem.mem_write <= id_ex.ctrl.mem_write;
			ex_mem.link      <= id_ex.ctrl.link;
		end
		ex_mem.alu_result <= alu_y;
		ex_mem.store_data <= rs2_val;
		ex_mem.rd         <= id_ex.rd;
		ex_mem.pc_plus4   <= id_ex.pc_plus4;
	end

	// decode never asks for a load and a store together
	a_no_rw_conflict: assert property (@(posedge clk) disable iff (!rst_n)
		!(ex_mem.mem_read && ex_mem.mem_write));

endmodule

// File: hdl/fetch_stage.sv
// fetch stage: program counter, next-pc select and IF/ID register
`include "core_config.svh"

module fetch_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             stall_id,
	input  logic             flush_if,
	input  logic             jump_taken,
	input  logic             branch_taken,
	input  logic [`XLEN-1:0] jump_target,
	input  logic [`XLEN-1:0] branch_target,
	input  logic [`XLEN-1:0] imem_data,
	output logic [`XLEN-1:0] imem_addr,
	output logic [`XLEN-1:0] if_instr,
	output logic [`XLEN-1:0] if_pc
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pc_next;

	assign imem_addr = pc;

	// branch in EX is older than anything in decode
	always_comb begin
		if (branch_taken)
			pc_next = branch_target;
		else if (stall_id)
			pc_next = pc;
		else if (jump_taken)
			pc_next = jump_target;
		else
			pc_next = pc + 4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RESET_PC;
		else
			pc <= pc_next;
	end

	// IF/ID, all-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (!rst_n || flush_if) begin
			if_instr <= '0;
			if_pc    <= '0;
		end else if (!stall_id) begin
			if_instr <= imem_data;
			if_pc    <= pc;
		end
	end

	// a taken branch must flush IF/ID and never leave it held
	a_branch_flushes: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |-> (flush_if && !stall_id));

endmodule

// File: hdl/hazard_forward.sv
// hazard and forwarding control: load-use and jalr stalls, flushes, forward selects
`include "core_config.svh"

module hazard_forward import core_pkg::*; (
	input  logic [`REG_ADDR_W-1:0] rs1_idx,
	input  logic [`REG_ADDR_W-1:0] rs2_idx,
	input  id_ex_t                 id_ex,
	input  ex_mem_t                ex_mem,
	input  mem_wb_t                mem_wb,
	input  logic                   branch_taken,
	input  logic                   jump_taken,
	output logic                   stall_id,
	output logic                   flush_if,
	output logic                   flush_id,
	output fwd_sel_e               fwd_a,
	output fwd_sel_e               fwd_b,
	output fwd_sel_e               fwd_jalr
);

	logic load_use;
	logic jalr_wait;

	// youngest producer wins, x0 never forwarded
	function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] idx,
		input ex_mem_t em, input mem_wb_t mw, input logic use_wb);
		fwd_sel_e sel;
		sel = FWD_RF;
		if (idx != '0) begin
			if (em.reg_write && em.rd == idx)
				sel = FWD_MEM;
			else if (use_wb && mw.reg_write && mw.rd == idx)
				sel = FWD_WB;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a    = pick_src(id_ex.rs1, ex_mem, mem_wb, 1'b1);
		fwd_b    = pick_src(id_ex.rs2, ex_mem, mem_wb, 1'b1);
		// WB reaches decode through the register file write-through
		fwd_jalr = pick_src(rs1_idx, ex_mem, mem_wb, 1'b0);
	end

	// ----------------------------------------------------------------------
	// stalls and flushes
	// ----------------------------------------------------------------------
	assign load_use = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
		(id_ex.rd == rs1_idx || id_ex.rd == rs2_idx);

	// jump base not yet available: producer in EX, or a load in MEM
	assign jalr_wait = jump_taken && (rs1_idx != '0) &&
		((id_ex.ctrl.reg_write && id_ex.rd == rs1_idx) ||
		(ex_mem.mem_read && ex_mem.rd == rs1_idx));

	// a taken branch kills decode anyway
	assign stall_id = (load_use || jalr_wait) && !branch_taken;
	assign flush_if = branch_taken || (jump_taken && !stall_id);
	assign flush_id = branch_taken;

endmodule

// File: hdl/reg_file.sv
// register file: two read ports, one write port, x0 fixed at zero, write-through
`include "core_config.svh"

module reg_file import core_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] rs1_idx,
	input  logic [`REG_ADDR_W-1:0] rs2_idx,
	input  mem_wb_t                wb,
	output logic [`XLEN-1:0]       rs1_data,
	output logic [`XLEN-1:0]       rs2_data
);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic             wr_en;

	// x0 is never written
	assign wr_en = wb.reg_write && (wb.rd != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb.rd] <= wb.wb_data;
		end
	end

	// same-cycle write is visible to decode
	assign rs1_data = (wr_en && wb.rd == rs1_idx) ? wb.wb_data : regs[rs1_idx];
	assign rs2_data = (wr_en && wb.rd == rs2_idx) ? wb.wb_data : regs[rs2_idx];

endmodule

// File: hdl/writeback_stage.sv
// writeback: result select in MEM and the MEM/WB register
`include "core_config.svh"

module writeback_stage import core_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  ex_mem_t          ex_mem,
	input  logic [`XLEN-1:0] dmem_rdata,
	output mem_wb_t          mem_wb
);

	logic [`XLEN-1:0] wb_value;

	// load data, else link address or ALU result
	assign wb_value = ex_mem.mem_read ? dmem_rdata : mem_result(ex_mem);

	always_ff @(posedge clk) begin
		if (!rst_n)
			mem_wb.reg_write <= 1'b0;
		else
			mem_wb.reg_write <= ex_mem.reg_write;
		mem_wb.wb_data <= wb_value;
		mem_wb.rd      <= ex_mem.rd;
	end

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f core_top.f

./obj_dir/Vtb_core > sim.log 2>&1 || {
	cat sim.log
	echo "simulator exited with an error"
	exit 1
}

cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "testbench reported failures"
	exit 1
fi

echo "testbench run complete"

// File: tb/tb_programs.svh
// test program table: instruction encoder, table builder tasks and expected store lists
localparam int NUM_TESTS  = 6;
localparam int PROG_WORDS = 16;
localparam int MAX_STORES = 8;

string       test_name  [NUM_TESTS];
logic [31:0] prog_word  [NUM_TESTS][PROG_WORDS];
int          prog_len   [NUM_TESTS];
int          exp_stores [NUM_TESTS];
logic [31:0] exp_addr   [NUM_TESTS][MAX_STORES];
logic [31:0] exp_data   [NUM_TESTS][MAX_STORES];
int          cur_test;

// operands: R rd rs1 rs2, I rd rs1 imm, sw rs2 base offset,
// branches rs1 rs2 offset, jal rd offset
function automatic logic [31:0] encode(input string op, input int a, input int b, input int c);
	logic [31:0] w;
	w = 32'h0;
	if (op == "add")
		w = {7'h00, c[4:0], b[4:0], 3'b000, a[4:0], 7'b0110011};
	else if (op == "sub")
		w = {7'h20, c[4:0], b[4:0], 3'b000, a[4:0], 7'b0110011};
	else if (op == "and")
		w = {7'h00, c[4:0], b[4:0], 3'b111, a[4:0], 7'b0110011};
	else if (op == "or")
		w = {7'h00, c[4:0], b[4:0], 3'b110, a[4:0], 7'b0110011};
	else if (op == "slt")
		w = {7'h00, c[4:0], b[4:0], 3'b010, a[4:0], 7'b0110011};
	else if (op == "addi")
		w = {c[11:0], b[4:0], 3'b000, a[4:0], 7'b0010011};
	else if (op == "lw")
		w = {c[11:0], b[4:0], 3'b010, a[4:0], 7'b0000011};
	else if (op == "jalr")
		w = {c[11:0], b[4:0], 3'b000, a[4:0], 7'b1100111};
	else if (op == "sw")
		w = {c[11:5], a[4:0], b[4:0], 3'b010, c[4:0], 7'b0100011};
	else if (op == "beq")
		w = {c[12], c[10:5], b[4:0], a[4:0], 3'b000, c[4:1], c[11], 7'b1100011};
	else if (op == "bne")
		w = {c[12], c[10:5], b[4:0], a[4:0], 3'b001, c[4:1], c[11], 7'b1100011};
	else if (op == "jal")
		w = {b[20], b[10:1], b[11], b[19:12], a[4:0], 7'b1101111};
	return w;
endfunction

task automatic new_test(input string name);
	cur_test++;
	test_name[cur_test]  = name;
	prog_len[cur_test]   = 0;
	exp_stores[cur_test] = 0;
endtask

task automatic emit(input string op, input int a, input int b, input int c);
	prog_word[cur_test][prog_len[cur_test]] = encode(op, a, b, c);
	prog_len[cur_test]++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
	exp_addr[cur_test][exp_stores[cur_test]] = addr;
	exp_data[cur_test][exp_stores[cur_test]] = data;
	exp_stores[cur_test]++;
endtask

// ----------------------------------------------------------------------
// program table
// ----------------------------------------------------------------------
task automatic build_programs();
	cur_test = -1;

	// back-to-back ALU dependencies, MEM and WB forwarding
	new_test("alu_forward");
	emit("addi", 1, 0, 5);
	emit("addi", 2, 1, 10);
	emit("add", 3, 1, 2);
	emit("sw", 3, 0, 0);
	emit("sub", 4, 3, 1);
	emit("and", 5, 4, 3);
	emit("sw", 4, 0, 4);
	emit("sw", 5, 0, 8);
	emit("or", 6, 3, 1);
	emit("slt", 7, 1, 3);
	emit("addi", 8, 0, -3);
	// 5 < -3 is false when signed
	emit("slt", 9, 1, 8);
	emit("sw", 6, 0, 12);
	emit("sw", 7, 0, 16);
	emit("sw", 9, 0, 20);
	emit("jal", 0, 0, 0);
	expect_store(0, 20);
	expect_store(4, 15);
	expect_store(8, 4);
	expect_store(12, 21);
	expect_store(16, 1);
	expect_store(20, 0);

	// load right before its use
	new_test("load_use");
	emit("addi", 1, 0, 100);
	emit("sw", 1, 0, 32);
	emit("lw", 2, 0, 32);
	emit("add", 3, 2, 1);
	emit("sw", 3, 0, 36);
	emit("lw", 4, 0, 36);
	emit("sw", 4, 0, 40);
	emit("jal", 0, 0, 0);
	expect_store(32, 100);
	expect_store(36, 200);
	expect_store(40, 200);

	// taken and fall-through beq / bne
	new_test("branches");
	emit("addi", 1, 0, 1);
	emit("addi", 2, 0, 2);
	emit("beq", 1, 2, 8);
	emit("sw", 1, 0, 0);
	emit("bne", 1, 2, 12);
	emit("sw", 1, 0, 4);
	emit("sw", 2, 0, 8);
	emit("sw", 2, 0, 12);
	emit("addi", 3, 1, 1);
	emit("beq", 3, 2, 8);
	emit("sw", 1, 0, 16);
	emit("sw", 3, 0, 20);
	emit("bne", 3, 2, 8);
	emit("sw", 1, 0, 24);
	emit("jal", 0, 0, 0);
	expect_store(0, 1);
	expect_store(12, 2);
	expect_store(20, 2);
	expect_store(24, 1);

	// jal link, jalr on a fresh register and on an old one
	new_test("jumps");
	emit("jal", 1, 12, 0);
	emit("sw", 1, 0, 8);
	emit("sw", 1, 0, 12);
	emit("sw", 1, 0, 0);
	emit("addi", 5, 0, 28);
	emit("jalr", 6, 5, 0);
	emit("sw", 5, 0, 8);
	emit("sw", 6, 0, 4);
	emit("jalr", 0, 5, 20);
	emit("sw", 5, 0, 12);
	emit("sw", 5, 0, 16);
	emit("sw", 5, 0, 20);
	emit("sw", 5, 0, 24);
	emit("jal", 0, 0, 0);
	expect_store(0, 4);
	expect_store(4, 24);
	expect_store(24, 28);

	// writes to x0 are dropped
	new_test("x0_write");
	emit("addi", 0, 0, 55);
	emit("addi", 1, 0, 7);
	emit("add", 0, 1, 1);
	emit("sw", 0, 0, 0);
	emit("addi", 2, 0, 3);
	emit("sw", 2, 0, 4);
	emit("lw", 0, 0, 4);
	emit("sw", 0, 0, 8);
	emit("sw", 1, 0, 12);
	emit("jal", 0, 0, 0);
	expect_store(0, 0);
	expect_store(4, 3);
	expect_store(8, 0);
	expect_store(12, 7);

	// memory access as the very first instruction
	new_test("first_mem");
	emit("sw", 0, 0, 60);
	emit("lw", 1, 0, 60);
	emit("addi", 2, 1, -1);
	emit("sw", 2, 0, 56);
	emit("jal", 0, 0, 0);
	expect_store(60, 0);
	expect_store(56, 32'hffff_ffff);
endtask

// File: tb/tb_core.sv
// testbench with clock, reset, memory models, program loop, checker, watchdog and summary
module tb_core;

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 16;
	localparam int RUN_CYCLES      = 64;
	localparam int QUIET_CYCLES    = 2;
	localparam int WATCHDOG_MARGIN = 2000;
	localparam int IMEM_WORDS      = 32;
	localparam int DMEM_WORDS      = 64;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        dmem_ren;
	logic        dmem_wen;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [IMEM_WORDS] = '{default: 32'h0};
	logic [31:0] dmem [DMEM_WORDS] = '{default: 32'h0};
	logic [31:0] written_addr [$];
	logic [31:0] written_data [$];
	int          errors;
	int          checks;

	`include "tb_programs.svh"

	core_top dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	// both memories answer combinationally
	// data reads return zero unless dmem_ren is up
	assign imem_data  = imem[imem_addr[6:2]];
	assign dmem_rdata = dmem_ren ? dmem[dmem_addr[7:2]] : 32'h0;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// data memory is cleared in reset and captures a write in the cycle its strobe is seen
	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] = 32'h0;
			written_addr.delete();
			written_data.delete();
		end else if (dmem_wen) begin
			dmem[dmem_addr[7:2]] = dmem_wdata;
			written_addr.push_back(dmem_addr);
			written_data.push_back(dmem_wdata);
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task automatic check_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", what, expected, actual);
		end
	endtask

	// no data port strobe expected
	task automatic check_quiet(input int t, input string phase);
		check_equal({test_name[t], " ", phase, " dmem_wen"}, 32'd0, {31'd0, dmem_wen});
		check_equal({test_name[t], " ", phase, " dmem_ren"}, 32'd0, {31'd0, dmem_ren});
	endtask

	task automatic compare_stores(input int t);
		int n;
		n = written_addr.size();
		checks++;
		if (n != exp_stores[t]) begin
			errors++;
			$display("%s: expected %0d stores on the data port but saw %0d",
				test_name[t], exp_stores[t], n);
		end
		if (n > exp_stores[t])
			n = exp_stores[t];
		for (int k = 0; k < n; k++) begin
			check_equal($sformatf("%s store %0d address", test_name[t], k),
				exp_addr[t][k], written_addr[k]);
			check_equal($sformatf("%s store %0d data", test_name[t], k),
				exp_data[t][k], written_data[k]);
		end
	endtask

	// ----------------------------------------------------------------------
	// program loop
	// ----------------------------------------------------------------------
	task automatic load_program(input int t);
		for (int i = 0; i < IMEM_WORDS; i++) begin
			if (i < prog_len[t])
				imem[i] = prog_word[t][i];
			else
				imem[i] = 32'h0;
		end
	endtask

	task automatic run_program(input int t);
		@(negedge clk);
		rst_n = 1'b0;
		load_program(t);
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			check_quiet(t, "in reset");
		end
		rst_n = 1'b1;
		// first two cycles after release only carry bubbles
		for (int i = 0; i < RUN_CYCLES; i++) begin
			@(negedge clk);
			if (i < QUIET_CYCLES)
				check_quiet(t, "after reset");
		end
		@(posedge clk);
	endtask

	initial begin
		rst_n  = 1'b0;
		errors = 0;
		checks = 0;
		build_programs();
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_program(t);
			compare_stores(t);
		end
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog sized from the per-program reset and run length
	initial begin
		#(NUM_TESTS * (RUN_CYCLES + RESET_CYCLES) * CLK_PERIOD + WATCHDOG_MARGIN);
		$display("timeout: the program loop did not finish in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
